/* hdl/logbuf_pkg.sv */
//--------------------
// shared definitions for the byte logging buffer
// word geometry, fifo depth and the tagged fifo entry
// modules import this inside their body, ports use scoped names
//--------------------

package logbuf_pkg;

  //--------------------
  // word geometry
  //--------------------

  // one byte lane
  localparam int BYTE_W = 8;

  // bytes packed into one word, little-endian lanes
  localparam int BYTES_PER_WORD = 4;

  localparam int WORD_W = BYTES_PER_WORD * BYTE_W;

  // byte count field, must hold the value BYTES_PER_WORD itself
  localparam int NBYTES_W = $clog2(BYTES_PER_WORD) + 1;

  //--------------------
  // fifo geometry
  //--------------------

  // must be a power of two, pointers wrap on their own
  localparam int FIFO_DEPTH = 8;

  // one extra bit so a count of FIFO_DEPTH fits
  localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

  //--------------------
  // fifo entry
  //--------------------

  // nbytes is 1..4, lanes above nbytes are always zero
  typedef struct packed {
    logic [NBYTES_W-1:0] nbytes;
    logic [WORD_W-1:0]   data;
  } log_entry_t;

endpackage

/* hdl/dual_port_ram.sv */
//--------------------
// simple dual-port block RAM, one clock
// one write port, one read port with a registered output
// written in the inference style both major FPGA vendors accept
//--------------------

`timescale 1ns/100ps

module dual_port_ram #(
  parameter int RAM_WIDTH = 16,
  parameter int RAM_DEPTH = 8
) (
  input  logic                         clk,

  // write port
  input  logic                         wr_en,
  input  logic [$clog2(RAM_DEPTH)-1:0] wr_addr,
  input  logic [RAM_WIDTH-1:0]         wr_data,

  // read port
  input  logic                         rd_en,
  input  logic [$clog2(RAM_DEPTH)-1:0] rd_addr,
  output logic [RAM_WIDTH-1:0]         rd_data
);

  logic [RAM_WIDTH-1:0] mem [RAM_DEPTH];

  // read register, the only output stage
  logic [RAM_WIDTH-1:0] rd_q = '0;

  // power-up contents are zero, matching the fpga bitstream
  initial begin
    for (int i = 0; i < RAM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read-during-write to the same address is never issued by the fifo
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_q <= mem[rd_addr];
    end
  end

  assign rd_data = rd_q;

endmodule

/* hdl/fifo_single_clock_ram.sv */
//--------------------
// single-clock fifo over a block RAM, normal mode only
// read data shows up one cycle after an accepted r_req
// overflow and underflow are refused and reported on fail
// r_ack marks the read requests that were actually taken
//--------------------

`timescale 1ns/100ps

module fifo_single_clock_ram #(
  parameter int DEPTH = logbuf_pkg::FIFO_DEPTH
) (
  input  logic                   clk,
  input  logic                   nrst,

  // write side
  input  logic                   w_req,
  input  logbuf_pkg::log_entry_t w_data,

  // read side
  input  logic                   r_req,
  output logbuf_pkg::log_entry_t r_data,
  output logic                   r_ack,

  // status
  output logic [$clog2(DEPTH):0] cnt,
  output logic                   empty,
  output logic                   full,
  output logic                   fail
);

  import logbuf_pkg::*;

  // DEPTH is a power of two, so plain pointers wrap by themselves
  localparam int PTR_W = $clog2(DEPTH);

  logic [PTR_W-1:0] w_ptr;
  logic [PTR_W-1:0] r_ptr;

  // requests after the full / empty filter
  logic w_req_f;
  logic r_req_f;

  //--------------------
  // request filter and flags
  //--------------------

  always_comb begin
    empty = (cnt == '0);
    full  = (cnt == DEPTH);

    w_req_f = w_req && !full;
    r_req_f = r_req && !empty;

    // same cycle as the refused request, state is left alone
    fail = (w_req && full) || (r_req && empty);
  end

  // the reader uses this instead of looking at empty again
  assign r_ack = r_req_f;

  //--------------------
  // pointers and count
  //--------------------

  always_ff @(posedge clk) begin
    if (!nrst) begin
      w_ptr <= '0;
      r_ptr <= '0;
      cnt   <= '0;
    end else begin
      if (w_req_f) begin
        w_ptr <= w_ptr + 1'b1;
      end
      if (r_req_f) begin
        r_ptr <= r_ptr + 1'b1;
      end

      // simultaneous push and pop keep the count
      if (w_req_f && !r_req_f) begin
        cnt <= cnt + 1'b1;
      end else if (!w_req_f && r_req_f) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  //--------------------
  // storage
  //--------------------

  // entry width follows the struct, nbytes tag included
  dual_port_ram #(
    .RAM_WIDTH ($bits(log_entry_t)),
    .RAM_DEPTH (DEPTH)
  ) data_ram (
    .clk     (clk),
    .wr_en   (w_req_f),
    .wr_addr (w_ptr),
    .wr_data (w_data),
    .rd_en   (r_req_f),
    .rd_addr (r_ptr),
    .rd_data (r_data)
  );

endmodule

/* hdl/byte_packer.sv */
//--------------------
// first pipeline stage of the logger
// collects byte strobes into little-endian words of four bytes
// a full word or a flush with pending bytes gives one push strobe,
// one cycle later, carrying the word and its byte count
//--------------------

`timescale 1ns/100ps

module byte_packer (
  input  logic                          clk,
  input  logic                          nrst,

  // producer side
  input  logic                          byte_strobe,
  input  logic [logbuf_pkg::BYTE_W-1:0] byte_data,
  input  logic                          flush,

  // towards the fifo, no full check here
  output logic                          push,
  output logbuf_pkg::log_entry_t        push_entry
);

  import logbuf_pkg::*;

  // bytes already collected, 0 .. BYTES_PER_WORD-1 between words
  logic [NBYTES_W-1:0] fill;

  // partly built word, unused lanes stay zero
  logic [WORD_W-1:0]   lanes;

  // state after taking this cycle's byte, before the flush
  logic [NBYTES_W-1:0] fill_next;
  logic [WORD_W-1:0]   lanes_next;

  // close the word this cycle
  logic                emit;

  //--------------------
  // lane insert
  //--------------------

  always_comb begin
    fill_next  = fill;
    lanes_next = lanes;

    // byte goes first, so a flush in the same cycle includes it
    if (byte_strobe) begin
      lanes_next[BYTE_W*fill +: BYTE_W] = byte_data;
      fill_next = fill + 1'b1;
    end

    // flush with nothing collected is a no-op
    emit = (fill_next == BYTES_PER_WORD) || (flush && (fill_next != '0));
  end

  //--------------------
  // control
  //--------------------

  always_ff @(posedge clk) begin
    if (!nrst) begin
      fill  <= '0;
      lanes <= '0;
      push  <= 1'b0;
    end else begin
      push <= emit;
      if (emit) begin
        // start the next word clean
        fill  <= '0;
        lanes <= '0;
      end else begin
        fill  <= fill_next;
        lanes <= lanes_next;
      end
    end
  end

  //--------------------
  // entry register
  //--------------------

  // only meaningful while push is high
  always_ff @(posedge clk) begin
    if (emit) begin
      push_entry.nbytes <= fill_next;
      push_entry.data   <= lanes_next;
    end
  end

endmodule

/* hdl/word_reader.sv */
//--------------------
// output stage of the logger
// forwards consumer read strobes to the fifo and lines up
// a valid pulse with the registered RAM data one cycle later
//--------------------

`timescale 1ns/100ps

module word_reader (
  input  logic                   clk,
  input  logic                   nrst,

  // consumer request
  input  logic                   rd_req,

  // fifo read side
  output logic                   r_req,
  input  logic                   r_ack,
  input  logbuf_pkg::log_entry_t r_data,

  // consumer output
  output logic                   out_valid,
  output logbuf_pkg::log_entry_t out_entry
);

  // read in flight, one per cycle at most
  logic ack_q;

  //--------------------
  // request path
  //--------------------

  // the fifo does the empty check and answers with r_ack
  assign r_req = rd_req;

  //--------------------
  // ack delay
  //--------------------

  // RAM data becomes valid one cycle after the ack,
  // a new read may already be in flight on that same cycle
  always_ff @(posedge clk) begin
    if (!nrst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= r_ack;
    end
  end

  assign out_valid = ack_q;

  // RAM read register holds the entry until the next accepted read
  assign out_entry = r_data;

endmodule

/* hdl/byte_logger_top.sv */
//--------------------
// byte-stream logging buffer, top level
// packer -> ram fifo -> reader, single clock
// bytes in as strobes, tagged words out one cycle after rd_req
// overflow and underflow show up as a fail pulse
//--------------------

`timescale 1ns/100ps

module byte_logger_top (
  input  logic                          clk,
  input  logic                          nrst,

  // producer
  input  logic                          byte_strobe,
  input  logic [logbuf_pkg::BYTE_W-1:0] byte_data,
  input  logic                          flush,

  // consumer
  input  logic                          rd_req,
  output logic                          out_valid,
  output logbuf_pkg::log_entry_t        out_entry,

  // fifo status
  output logic [logbuf_pkg::CNT_W-1:0]  cnt,
  output logic                          empty,
  output logic                          full,
  output logic                          fail
);

  import logbuf_pkg::*;

  // packer to fifo
  logic       push;
  log_entry_t push_entry;

  // fifo to reader
  logic       r_req;
  logic       r_ack;
  log_entry_t r_data;

  byte_packer packer (
    .clk         (clk),
    .nrst        (nrst),
    .byte_strobe (byte_strobe),
    .byte_data   (byte_data),
    .flush       (flush),
    .push        (push),
    .push_entry  (push_entry)
  );

  fifo_single_clock_ram #(
    .DEPTH (FIFO_DEPTH)
  ) fifo (
    .clk    (clk),
    .nrst   (nrst),
    .w_req  (push),
    .w_data (push_entry),
    .r_req  (r_req),
    .r_data (r_data),
    .r_ack  (r_ack),
    .cnt    (cnt),
    .empty  (empty),
    .full   (full),
    .fail   (fail)
  );

  word_reader reader (
    .clk       (clk),
    .nrst      (nrst),
    .rd_req    (rd_req),
    .r_req     (r_req),
    .r_ack     (r_ack),
    .r_data    (r_data),
    .out_valid (out_valid),
    .out_entry (out_entry)
  );

endmodule

/* bench/byte_logger_asserts.sv */
//--------------------
// concurrent checks on the ram fifo, attached by bind
// count range, flag decode, fail pulse and read ack
//--------------------

`timescale 1ns/100ps

module byte_logger_asserts #(
  parameter int DEPTH = logbuf_pkg::FIFO_DEPTH
) (
  input logic                   clk,
  input logic                   nrst,
  input logic                   w_req,
  input logic                   r_req,
  input logic                   r_ack,
  input logic [$clog2(DEPTH):0] cnt,
  input logic                   empty,
  input logic                   full,
  input logic                   fail
);

  // occupancy never goes past the depth
  cnt_in_range: assert property (@(posedge clk) disable iff (!nrst) cnt <= DEPTH)
    else $error("fifo count %0d above depth %0d", cnt, DEPTH);

  // one flag at most
  flags_exclusive: assert property (@(posedge clk) disable iff (!nrst) !(empty && full))
    else $error("fifo empty and full together");

  // with a single request the count holds exactly when that request was refused
  fail_on_refused: assert property (@(posedge clk) disable iff (!nrst)
      (w_req != r_req) |=> ((cnt == $past(cnt)) == $past(fail)))
    else $error("fifo fail does not match a refused request");

  // an acknowledged read takes one entry, so an empty fifo never acks
  no_ack_when_empty: assert property (@(posedge clk) disable iff (!nrst)
      (r_ack && !w_req) |=> (cnt == $past(cnt) - 1))
    else $error("fifo read acknowledged while empty");

endmodule

bind fifo_single_clock_ram byte_logger_asserts #(.DEPTH(DEPTH)) fifo_checks (
  .clk   (clk),
  .nrst  (nrst),
  .w_req (w_req),
  .r_req (r_req),
  .r_ack (r_ack),
  .cnt   (cnt),
  .empty (empty),
  .full  (full),
  .fail  (fail)
);

/* bench/byte_logger_tb.sv */
//--------------------
// directed testbench for the byte logging buffer
// stimulus goes through one step task per clock, which also
// checks every out_valid against a reference queue built
// from the packing rule while fifo status is checked between steps
//--------------------

`timescale 1ns/100ps

module byte_logger_tb;

  import logbuf_pkg::*;

  // longest wait for an outstanding read in cycles
  localparam int READ_TIMEOUT = 20;

  logic              clk;
  logic              nrst;
  logic              byte_strobe;
  logic [BYTE_W-1:0] byte_data;
  logic              flush;
  logic              rd_req;
  logic              out_valid;
  log_entry_t        out_entry;
  logic [CNT_W-1:0]  cnt;
  logic              empty;
  logic              full;
  logic              fail;

  // words the fifo should hold, oldest first
  log_entry_t        model_q[$];
  // reads in flight and the cycle their output is due
  log_entry_t        pend_q[$];
  int                due_q[$];
  // word the packer is building
  logic [WORD_W-1:0] pend_data;
  int                pend_n;
  int                cyc;
  int                fail_count;
  logic [31:0]       lfsr;
  string             test_name;

  byte_logger_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //--------------------
  // reporting and compares
  //--------------------

  task automatic fail_and_stop();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_entry(input log_entry_t exp, input log_entry_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: entry expected %0d/%h actual %0d/%h",
               test_name, exp.nbytes, exp.data, act.nbytes, act.data);
      fail_and_stop();
    end
  endtask

  // cnt, empty and full in one go
  task automatic check_flags(input logic [CNT_W-1:0] exp_cnt, input logic exp_empty,
                             input logic exp_full);
    if ({cnt, empty, full} !== {exp_cnt, exp_empty, exp_full}) begin
      $display("CHECK FAILED %s: cnt/empty/full expected %0d/%b/%b actual %0d/%b/%b",
               test_name, exp_cnt, exp_empty, exp_full, cnt, empty, full);
      fail_and_stop();
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
      fail_and_stop();
    end
  endtask

  //--------------------
  // random bytes
  //--------------------

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic random_byte(output logic [BYTE_W-1:0] b);
    for (int i = 0; i < BYTE_W; i++) begin
      b[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  //--------------------
  // reference model
  //--------------------

  // the byte goes in before the flush and lanes fill from the bottom
  task automatic model_bytes(input logic strobe, input logic [BYTE_W-1:0] data,
                             input logic fl);
    log_entry_t e;
    if (strobe) begin
      pend_data[BYTE_W*pend_n +: BYTE_W] = data;
      pend_n++;
    end
    if (pend_n == BYTES_PER_WORD || (fl && pend_n != 0)) begin
      e.nbytes = pend_n;
      e.data   = pend_data;
      // a word that meets a full fifo is lost
      if (model_q.size() < FIFO_DEPTH) begin
        model_q.push_back(e);
      end
      pend_data = '0;
      pend_n    = 0;
    end
  endtask

  //--------------------
  // one clock of stimulus
  //--------------------

  // drive on the rising edge and look at outputs on the falling edge
  task automatic step(input logic strobe, input logic [BYTE_W-1:0] data,
                      input logic fl, input logic rd);
    log_entry_t exp;
    int         due;
    @(posedge clk);
    byte_strobe <= strobe;
    byte_data   <= data;
    flush       <= fl;
    rd_req      <= rd;
    cyc++;
    model_bytes(strobe, data, fl);
    // a read of an empty fifo gives nothing
    if (rd && model_q.size() != 0) begin
      pend_q.push_back(model_q.pop_front());
      due_q.push_back(cyc + 1);
    end
    @(negedge clk);
    if (fail) begin
      fail_count++;
    end
    if (out_valid) begin
      if (pend_q.size() == 0) begin
        $display("ERROR %s: out_valid at cycle %0d without an accepted read",
                 test_name, cyc);
        fail_and_stop();
      end
      exp = pend_q.pop_front();
      due = due_q.pop_front();
      if (due != cyc) begin
        $display("ERROR %s: out_valid at cycle %0d for a read due at cycle %0d",
                 test_name, cyc, due);
        fail_and_stop();
      end
      check_entry(exp, out_entry);
    end
    if (due_q.size() != 0 && due_q[0] <= cyc) begin
      $display("ERROR %s: no out_valid one cycle after an accepted read", test_name);
      fail_and_stop();
    end
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b0, '0, 1'b0, 1'b0);
  endtask

  // n random bytes with an optional flush on the last one
  task automatic send_bytes(input int n, input logic flush_last);
    logic [BYTE_W-1:0] b;
    for (int i = 0; i < n; i++) begin
      random_byte(b);
      step(1'b1, b, flush_last && (i == n - 1), 1'b0);
    end
  endtask

  task automatic wait_reads_done();
    int n;
    n = 0;
    while (pend_q.size() != 0) begin
      if (n == READ_TIMEOUT) begin
        $display("ERROR %s: reads still outstanding after %0d cycles", test_name, n);
        fail_and_stop();
      end
      step(1'b0, '0, 1'b0, 1'b0);
      n++;
    end
  endtask

  // back-to-back reads until the model is empty
  task automatic read_all();
    while (model_q.size() != 0) begin
      step(1'b0, '0, 1'b0, 1'b1);
    end
    wait_reads_done();
  endtask

  //--------------------
  // tests
  //--------------------

  task automatic test_reset();
    test_name = "reset";
    idle(1);
    check_flags(0, 1'b1, 1'b0);
    check_count("fail pulses", 0, fail_count);
  endtask

  task automatic test_full_words();
    int start;
    test_name = "full words";
    start     = fail_count;
    send_bytes(12, 1'b0);
    idle(2);
    check_flags(3, 1'b0, 1'b0);
    // one idle cycle after each read
    repeat (3) begin
      step(1'b0, '0, 1'b0, 1'b1);
      step(1'b0, '0, 1'b0, 1'b0);
    end
    wait_reads_done();
    check_flags(0, 1'b1, 1'b0);
    check_count("fail pulses", start, fail_count);
  endtask

  task automatic test_flush();
    test_name = "flush";
    send_bytes(1, 1'b0);
    step(1'b0, '0, 1'b1, 1'b0);
    send_bytes(2, 1'b0);
    step(1'b0, '0, 1'b1, 1'b0);
    // flush in the same cycle as the third byte
    send_bytes(3, 1'b1);
    // flush with nothing pending gives no entry
    step(1'b0, '0, 1'b1, 1'b0);
    idle(2);
    check_flags(3, 1'b0, 1'b0);
    read_all();
    check_flags(0, 1'b1, 1'b0);
  endtask

  task automatic test_overflow();
    int start;
    test_name = "overflow";
    start     = fail_count;
    send_bytes(9 * BYTES_PER_WORD, 1'b0);
    idle(2);
    check_flags(FIFO_DEPTH, 1'b0, 1'b1);
    check_count("fail pulses", start + 1, fail_count);
    read_all();
    check_flags(0, 1'b1, 1'b0);
  endtask

  task automatic test_empty_read();
    int start;
    test_name = "empty read";
    start     = fail_count;
    step(1'b0, '0, 1'b0, 1'b1);
    check_count("fail pulses", start + 1, fail_count);
    // window in which no out_valid may show up
    idle(5);
    check_flags(0, 1'b1, 1'b0);
  endtask

  task automatic test_interleaved();
    logic [BYTE_W-1:0] b;
    test_name = "interleaved";
    for (int r = 0; r < 3; r++) begin
      while (model_q.size() < 4) begin
        send_bytes(BYTES_PER_WORD, 1'b0);
      end
      idle(2);
      check_flags(model_q.size(), 1'b0, 1'b0);
      // a byte every cycle and reads on the first four
      for (int i = 0; i < 8; i++) begin
        random_byte(b);
        step(1'b1, b, 1'b0, i < 4);
      end
      wait_reads_done();
      idle(2);
      check_flags(model_q.size(), model_q.size() == 0, 1'b0);
    end
    read_all();
    check_flags(0, 1'b1, 1'b0);
  endtask

  initial begin
    nrst        = 1'b0;
    byte_strobe = 1'b0;
    byte_data   = '0;
    flush       = 1'b0;
    rd_req      = 1'b0;
    pend_data   = '0;
    pend_n      = 0;
    cyc         = 0;
    fail_count  = 0;
    lfsr        = 32'h60c81c74;
    test_name   = "init";
    repeat (16) @(posedge clk);
    nrst <= 1'b1;
    test_reset();
    test_full_words();
    test_flush();
    test_overflow();
    test_empty_read();
    test_interleaved();
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* all.f */
hdl/logbuf_pkg.sv
hdl/dual_port_ram.sv
hdl/fifo_single_clock_ram.sv
hdl/byte_packer.sv
hdl/word_reader.sv
hdl/byte_logger_top.sv
bench/byte_logger_asserts.sv
bench/byte_logger_tb.sv

/* Bender.yml */
package:
  name: byte_logger

sources:
  # synthesizable design, package first
  - files:
      - hdl/logbuf_pkg.sv
      - hdl/dual_port_ram.sv
      - hdl/fifo_single_clock_ram.sv
      - hdl/byte_packer.sv
      - hdl/word_reader.sv
      - hdl/byte_logger_top.sv
  # testbench, top module byte_logger_tb
  - target: test
    files:
      - bench/byte_logger_asserts.sv
      - bench/byte_logger_tb.sv
